// File: Makefile
VERILATOR ?= verilator
TOP       ?= fpsqr_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q '\*\*\* PASSED \*\*\*' $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: hw/fpsqr_core.sv
`timescale 1ns/1ns
`include "fpsqr_params.svh"

module fpsqr_core import fpsqr_pkg::*; (
  input  logic      clk,
  input  logic      arst_n,
  input  logic      start,
  input  fp_word_t  opnd,
  output logic      busy,
  output logic      done,
  output fp_word_t  result,
  output fp_flags_t flags
);

  localparam logic [4:0] RND_STEP  = 5'(`FPSQR_ITERS);
  localparam logic [4:0] PACK_STEP = 5'(`FPSQR_LAT - 1);

  logic        sgn;
  logic [7:0]  exp_in;
  logic [22:0] frac_in;
  logic [8:0]  exp_sum;
  logic        is_spec;
  fp_word_t    spec_val;
  fp_flags_t   spec_flg;
  logic        accept;
  logic [4:0]  cnt;

  logic        spec_q;
  fp_word_t    spec_val_q;
  fp_flags_t   spec_flg_q;
  logic [7:0]  exp_q;
  logic [51:0] rad;           // Radicand, 2 integer bits
  logic [29:0] rem;
  logic [25:0] root;
  logic [24:0] mant_q;        // Rounded mantissa with carry
  logic        inx_q;

  logic [29:0] rem_t;
  logic [29:0] trial;
  logic        take;
  logic        guard;
  logic        sticky;
  logic        rnd_up;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Unpack and classify
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign {sgn, exp_in, frac_in} = opnd;
  assign exp_sum = {1'b0, exp_in} + 9'd127;  // Halved below, parity folds in
  assign accept  = start && !busy;

  always_comb begin
    is_spec  = 1'b1;
    spec_val = CANON_NAN;
    spec_flg = '0;
    if (exp_in == 8'hff && frac_in != '0) begin
      spec_flg[FLAG_INVALID] = ~frac_in[22];  // Signaling NaN
    end else if (exp_in == '0) begin
      spec_val = {sgn, 31'b0};                 // Zero, denormal flushed
    end else if (sgn) begin
      spec_flg[FLAG_INVALID] = 1'b1;
    end else if (exp_in == 8'hff) begin
      spec_val = opnd;                         // +inf
    end else begin
      is_spec = 1'b0;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Restoring root step and rounding
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign rem_t  = {rem[27:0], rad[51:50]};
  assign trial  = {2'b00, root, 2'b01};
  assign take   = (rem_t >= trial);

  assign guard  = root[1];
  assign sticky = root[0] | (rem != '0);
  assign rnd_up = guard & (sticky | root[2]);  // Nearest even

  always_ff @(posedge clk) begin
    if (accept) begin
      spec_q     <= is_spec;
      spec_val_q <= spec_val;
      spec_flg_q <= spec_flg;
      exp_q      <= exp_sum[8:1];
      // Odd unbiased exponent doubles the radicand
      rad        <= exp_in[0] ? {2'b01, frac_in, 27'b0} : {1'b1, frac_in, 28'b0};
      rem        <= '0;
      root       <= '0;
    end else if (busy && cnt < RND_STEP) begin
      rem  <= take ? rem_t - trial : rem_t;
      root <= {root[24:0], take};
      rad  <= rad << 2;
    end else if (busy && cnt == RND_STEP) begin
      mant_q <= {1'b0, root[25:2]} + {24'b0, rnd_up};
      inx_q  <= guard | sticky;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Sequencing and pack
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      busy   <= 1'b0;
      done   <= 1'b0;
      cnt    <= '0;
      result <= '0;
      flags  <= '0;
    end else if (accept) begin
      busy <= 1'b1;
      cnt  <= '0;
    end else if (done) begin
      busy <= 1'b0;  // Held through the result cycle
      done <= 1'b0;
    end else if (busy) begin
      cnt <= cnt + 5'd1;
      if (cnt == PACK_STEP) begin
        done   <= 1'b1;
        result <= spec_q ? spec_val_q
                         : {1'b0, exp_q + {7'b0, mant_q[24]}, mant_q[22:0]};
        flags  <= spec_q ? spec_flg_q : {inx_q, 1'b0};  // Inexact only
      end
    end
  end

  assert property (@(posedge clk) disable iff (!arst_n) start |-> !busy)
    else $error("fpsqr_core: start while busy");

  assert property (@(posedge clk) disable iff (!arst_n) accept |=> ##`FPSQR_LAT done)
    else $error("fpsqr_core: result not on time");

endmodule

// File: hw/fpsqr_csr.sv
`timescale 1ns/1ns

module fpsqr_csr import fpsqr_pkg::*; (
  input  logic       clk,
  input  logic       arst_n,
  input  logic       csr_we,
  input  logic [3:0] csr_wdata,
  input  fp_flags_t  flag_accrue,
  input  logic       flag_accrue_en,
  output logic [3:0] csr_rdata,
  output fp_flags_t  trap_en
);

  fp_flags_t sticky;
  fp_flags_t raised;

  assign raised = flag_accrue_en ? flag_accrue : '0;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Trap enables and sticky flags
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      sticky  <= '0;
      trap_en <= '0;
    end else if (csr_we) begin
      sticky  <= csr_wdata[1:0] | raised;  // Completion in the write cycle still lands
      trap_en <= csr_wdata[3:2];
    end else begin
      sticky <= sticky | raised;
    end
  end

  assign csr_rdata = {trap_en, sticky};

endmodule

// File: hw/fpsqr_opsel.sv
`timescale 1ns/1ns
`include "fpsqr_params.svh"

module fpsqr_opsel import fpsqr_pkg::*; (
  input  fp_word_t                          opnd,
  input  fp_word_t [`FPSQR_FWD_SRCS-1:0]    fwd,
  input  logic     [`FPSQR_FWD_SRCS-1:0]    fwd_sel,
  output fp_word_t                          sel_opnd
);

  // AND-OR mux, no priority between buses
  always_comb begin
    sel_opnd = (fwd_sel == '0) ? opnd : '0;  // Register value when nothing forwards
    for (int i = 0; i < `FPSQR_FWD_SRCS; i++) begin
      sel_opnd = sel_opnd | (fwd[i] & {32{fwd_sel[i]}});
    end
  end

  // Two buses at once would OR their words together
  always_comb begin
    assert ($onehot0(fwd_sel))
      else $error("fpsqr_opsel: fwd_sel not one-hot (%b)", fwd_sel);
  end

endmodule

// File: hw/fpsqr_params.svh
`ifndef FPSQR_PARAMS_SVH
`define FPSQR_PARAMS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Unit geometry
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define FPSQR_LANES 2     // Low and high lane
`define FPSQR_FWD_SRCS 4  // Forwarding buses per lane

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Core timing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// 24 mantissa bits, guard bit, sticky step
`define FPSQR_ITERS 26

// Unpack, iterations, round, pack
`define FPSQR_LAT 28

`endif

// File: hw/fpsqr_pkg.sv
package fpsqr_pkg;

  // IEEE single
  typedef logic [31:0] fp_word_t;

  // Accrued exception flags
  typedef logic [1:0] fp_flags_t;

  localparam int FLAG_INVALID = 0;
  localparam int FLAG_INEXACT = 1;

  // Cause field of the retire code
  typedef enum logic [2:0] {
    XCPT_NONE    = 3'd0,
    XCPT_INVALID = 3'd1,
    XCPT_INEXACT = 3'd2
  } xcpt_cause_t;

  localparam fp_word_t CANON_NAN = 32'h7fc0_0000;  // Positive quiet NaN

endpackage

// File: hw/fpsqr_unit.sv
`timescale 1ns/1ns
`include "fpsqr_params.svh"

module fpsqr_unit import fpsqr_pkg::*; (
  input  logic                                clk,
  input  logic                                arst_n,
  input  logic                                issue,
  input  logic     [`FPSQR_LANES-1:0]         lane_en,
  input  fp_word_t                            opnd_lo,
  input  fp_word_t                            opnd_hi,
  input  logic     [`FPSQR_FWD_SRCS-1:0]      fwd_sel,
  input  fp_word_t [`FPSQR_FWD_SRCS-1:0]      fwd_lo,
  input  fp_word_t [`FPSQR_FWD_SRCS-1:0]      fwd_hi,
  input  logic                                csr_we,
  input  logic     [3:0]                      csr_wdata,
  output logic     [3:0]                      csr_rdata,
  output logic                                busy,
  output logic                                res_valid,
  output fp_word_t                            res_lo,
  output fp_word_t                            res_hi,
  output logic                                ret_en,
  output logic     [3:0]                      ret_code
);

  fp_word_t                   sel_lo;
  fp_word_t                   sel_hi;
  logic                       busy_lo;
  logic                       busy_hi;
  logic                       done_lo;
  fp_flags_t                  flags_lo;
  fp_flags_t                  flags_hi;
  logic [`FPSQR_LANES-1:0]    lane_en_q;
  fp_flags_t                  trap_en;
  fp_flags_t                  flag_accrue;
  logic                       flag_accrue_en;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Lanes
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  fpsqr_opsel opsel_lo_i (.opnd(opnd_lo), .fwd(fwd_lo), .fwd_sel(fwd_sel), .sel_opnd(sel_lo));
  fpsqr_opsel opsel_hi_i (.opnd(opnd_hi), .fwd(fwd_hi), .fwd_sel(fwd_sel), .sel_opnd(sel_hi));

  fpsqr_core core_lo_i (
    .clk(clk), .arst_n(arst_n), .start(issue), .opnd(sel_lo),
    .busy(busy_lo), .done(done_lo), .result(res_lo), .flags(flags_lo)
  );

  // Lockstep with the low lane, which paces completion
  fpsqr_core core_hi_i (
    .clk(clk), .arst_n(arst_n), .start(issue), .opnd(sel_hi),
    .busy(busy_hi), .done(), .result(res_hi), .flags(flags_hi)
  );

  assign busy      = busy_lo | busy_hi;
  assign res_valid = done_lo;

  // Lane mask for the completing item
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      lane_en_q <= '0;
    end else if (issue && !busy) begin
      lane_en_q <= lane_en;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Exceptions and CSR
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  fpsqr_xcpt xcpt_i (
    .done(done_lo), .lane_en(lane_en_q), .flags_lo(flags_lo), .flags_hi(flags_hi),
    .trap_en(trap_en), .flag_accrue(flag_accrue), .flag_accrue_en(flag_accrue_en),
    .ret_code(ret_code), .ret_en(ret_en)
  );

  fpsqr_csr csr_i (
    .clk(clk), .arst_n(arst_n), .csr_we(csr_we), .csr_wdata(csr_wdata),
    .flag_accrue(flag_accrue), .flag_accrue_en(flag_accrue_en),
    .csr_rdata(csr_rdata), .trap_en(trap_en)
  );

endmodule

// File: hw/fpsqr_xcpt.sv
`timescale 1ns/1ns
`include "fpsqr_params.svh"

module fpsqr_xcpt import fpsqr_pkg::*; (
  input  logic                     done,
  input  logic [`FPSQR_LANES-1:0]  lane_en,
  input  fp_flags_t                flags_lo,
  input  fp_flags_t                flags_hi,
  input  fp_flags_t                trap_en,
  output fp_flags_t                flag_accrue,
  output logic                     flag_accrue_en,
  output logic [3:0]               ret_code,
  output logic                     ret_en
);

  fp_flags_t lane_flg [`FPSQR_LANES];
  fp_flags_t trapped;
  logic      found;

  // Disabled lanes drop out entirely
  assign lane_flg[0] = flags_lo & {2{lane_en[0]}};
  assign lane_flg[1] = flags_hi & {2{lane_en[1]}};

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Merge and cause priority
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    flag_accrue = '0;
    ret_code    = '0;
    trapped     = '0;
    found       = 1'b0;
    for (int i = 0; i < `FPSQR_LANES; i++) begin
      if (done) begin
        flag_accrue = flag_accrue | lane_flg[i];
      end
      trapped = lane_flg[i] & trap_en;
      // Low lane first, invalid over inexact
      if (done && !found && trapped != '0) begin
        found         = 1'b1;
        ret_code[3]   = 1'(i);
        ret_code[2:0] = trapped[FLAG_INVALID] ? XCPT_INVALID : XCPT_INEXACT;
      end
    end
  end

  assign flag_accrue_en = done;
  assign ret_en         = done;

  // ROB reads the code only with ret_en
  always_comb begin
    assert (ret_en || ret_code == '0)
      else $error("fpsqr_xcpt: ret_code %h without ret_en", ret_code);
  end

endmodule

// File: sim.f
+incdir+hw
hw/fpsqr_pkg.sv
hw/fpsqr_csr.sv
hw/fpsqr_opsel.sv
hw/fpsqr_core.sv
hw/fpsqr_xcpt.sv
hw/fpsqr_unit.sv
sim/fpsqr_tb.sv

// File: sim/fpsqr_tb.sv
`timescale 1ns/1ns
`include "fpsqr_params.svh"

module fpsqr_tb import fpsqr_pkg::*;;

  localparam int TIMEOUT = 60 * 30 + 100;

  logic clk = 1'b0;
  logic arst_n = 1'b0;
  logic issue = 1'b0;
  logic [1:0] lane_en = '0;
  fp_word_t opnd_lo = '0;
  fp_word_t opnd_hi = '0;
  logic [3:0] fwd_sel = '0;
  fp_word_t [3:0] fwd_lo = '0;
  fp_word_t [3:0] fwd_hi = '0;
  logic csr_we = 1'b0;
  logic [3:0] csr_wdata = '0;
  logic [3:0] csr_rdata;
  logic busy, res_valid, ret_en;
  fp_word_t res_lo, res_hi;
  logic [3:0] ret_code;

  fp_word_t exp_lo, exp_hi;
  logic [3:0] exp_code = '0;
  fp_flags_t exp_sticky = '0;  // Model of the CSR
  fp_flags_t exp_trap = '0;
  logic csr_chk = 1'b0;
  int errors = 0;
  int ops = 0;
  int cycles = 0;

  fpsqr_unit fpsqr_unit_i (.*);

  always #5 clk = ~clk;

  task automatic report(input string name, input logic [31:0] expv, input logic [31:0] actv);
    errors++;
    $display("** Error at %0t ns: %s expected %h, got %h", $time, name, expv, actv);
  endtask

  task automatic fault(input string what);
    errors++;
    $display("Failure at %0t ns: %s", $time, what);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Checks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assert property (@(posedge clk) !arst_n |-> !busy && !res_valid && !ret_en)
    else fault("busy, res_valid or ret_en high during reset");
  assert property (@(posedge clk) disable iff (!arst_n) res_valid |-> res_lo == exp_lo)
    else report("res_lo", exp_lo, res_lo);
  assert property (@(posedge clk) disable iff (!arst_n) res_valid |-> res_hi == exp_hi)
    else report("res_hi", exp_hi, res_hi);
  assert property (@(posedge clk) disable iff (!arst_n) res_valid |-> ret_code == exp_code)
    else report("ret_code", {28'b0, exp_code}, {28'b0, ret_code});
  assert property (@(posedge clk) disable iff (!arst_n) ret_en == res_valid)
    else fault("ret_en does not match res_valid");
  assert property (@(posedge clk) disable iff (!arst_n)
    csr_chk |-> csr_rdata == {exp_trap, exp_sticky})
    else report("csr_rdata", {28'b0, exp_trap, exp_sticky}, {28'b0, csr_rdata});
  assert property (@(posedge clk) disable iff (!arst_n) issue && !busy |=>
    (busy && !res_valid) [*`FPSQR_LAT] ##1 (busy && res_valid))
    else fault("busy or res_valid timing wrong after issue");

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Reference model and stimulus
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  function automatic fp_word_t int_to_float(input int unsigned k);
    int p;
    p = 31;
    while (k[p] == 1'b0) p--;
    return {1'b0, 8'(127 + p), 23'((k << (23 - p)) & 32'h7f_ffff)};
  endfunction

  // Low lane first, invalid before inexact
  function automatic logic [3:0] cause_of(input fp_flags_t fl, input fp_flags_t fh,
                                          input logic [1:0] en, input fp_flags_t trap);
    fp_flags_t tl;
    fp_flags_t th;
    tl = fl & trap & {2{en[0]}};
    th = fh & trap & {2{en[1]}};
    if (tl[0]) return 4'h1;
    if (tl[1]) return 4'h2;
    if (th[0]) return 4'h9;
    if (th[1]) return 4'ha;
    return 4'h0;
  endfunction

  task automatic run_op(input fp_word_t a, input fp_word_t b, input logic [3:0] sel,
                        input logic [1:0] en, input fp_word_t ea, input fp_word_t eb,
                        input fp_flags_t fa, input fp_flags_t fb);
    opnd_lo = a;
    opnd_hi = b;
    fwd_sel = sel;
    lane_en = en;
    exp_lo = ea;
    exp_hi = eb;
    exp_code = cause_of(fa, fb, en, exp_trap);
    issue = 1'b1;
    @(negedge clk);
    issue = 1'b0;
    while (!res_valid) @(negedge clk);
    @(negedge clk);  // Sticky bits land on this edge
    exp_sticky = exp_sticky | (fa & {2{en[0]}}) | (fb & {2{en[1]}});
    ops++;
  endtask

  task automatic write_csr(input logic [3:0] v);
    csr_we = 1'b1;
    csr_wdata = v;
    @(negedge clk);
    csr_we = 1'b0;
    exp_sticky = v[1:0];
    exp_trap = v[3:2];
  endtask

  task automatic check_csr;
    csr_chk = 1'b1;
    @(negedge clk);
    csr_chk = 1'b0;
  endtask

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT) begin
      $display("Timeout after %0d cycles, %0d operations done, %0d errors", cycles, ops, errors);
      $display("*** FAILED ***");
      $finish;
    end
  end

  initial begin
    int unsigned k;
    int unsigned k2;
    void'($urandom(49));
    repeat (4) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    @(negedge clk);
    check_csr;
    for (int i = 0; i < 16; i++) begin
      k = $urandom_range(4095, 1);
      k2 = $urandom_range(4095, 1);
      run_op(int_to_float(k * k), int_to_float(k2 * k2), 4'b0, 2'b11,
             int_to_float(k), int_to_float(k2), 2'b00, 2'b00);
    end
    for (int i = 0; i < 4; i++) begin
      fwd_lo[i] = int_to_float((i + 3) * (i + 3));
      fwd_hi[i] = int_to_float((i + 11) * (i + 11));
    end
    run_op(32'h4080_0000, 32'h4110_0000, 4'b0000, 2'b11, 32'h4000_0000, 32'h4040_0000, 0, 0);
    for (int i = 0; i < 4; i++) begin
      run_op(32'h4000_0001, 32'h4000_0001, 4'(1 << i), 2'b11,
             int_to_float(i + 3), int_to_float(i + 11), 2'b00, 2'b00);
    end
    // Special operands
    run_op(32'hc080_0000, 32'h7f80_0001, 4'b0, 2'b11, CANON_NAN, CANON_NAN, 2'b01, 2'b01);
    run_op(32'h7fc0_0123, 32'h7f80_0000, 4'b0, 2'b11, CANON_NAN, 32'h7f80_0000, 2'b00, 2'b00);
    run_op(32'h0000_0000, 32'h8000_0000, 4'b0, 2'b11, 32'h0000_0000, 32'h8000_0000, 0, 0);
    run_op(32'h0000_0001, 32'h8040_0000, 4'b0, 2'b11, 32'h0000_0000, 32'h8000_0000, 0, 0);
    check_csr;
    write_csr(4'b0000);
    check_csr;
    // Traps, priority and lane enables
    write_csr(4'b1100);
    run_op(32'h4000_0000, 32'h4080_0000, 4'b0, 2'b11, 32'h3fb5_04f3, 32'h4000_0000, 2'b10, 0);
    check_csr;
    run_op(32'h4080_0000, 32'hbf80_0000, 4'b0, 2'b11, 32'h4000_0000, CANON_NAN, 2'b00, 2'b01);
    run_op(32'h4000_0000, 32'hbf80_0000, 4'b0, 2'b11, 32'h3fb5_04f3, CANON_NAN, 2'b10, 2'b01);
    run_op(32'hbf80_0000, 32'h4000_0000, 4'b0, 2'b11, CANON_NAN, 32'h3fb5_04f3, 2'b01, 2'b10);
    write_csr(4'b1100);
    run_op(32'h4080_0000, 32'hbf80_0000, 4'b0, 2'b01, 32'h4000_0000, CANON_NAN, 2'b00, 2'b01);
    check_csr;
    write_csr(4'b1000);
    run_op(32'hbf80_0000, 32'h4000_0000, 4'b0, 2'b11, CANON_NAN, 32'h3fb5_04f3, 2'b01, 2'b10);
    check_csr;
    repeat (3) @(negedge clk);
    $display("Run complete: %0d operations, %0d errors", ops, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule
